//--- verilog/pod_settings.svh
//////////////////////////////
// Capture path sizes: channels, words, blocks
// FIFO depth and priority threshold, DRAM address fields
//////////////////////////////

`ifndef POD_SETTINGS_SVH
`define POD_SETTINGS_SVH

// Channel count and channel number width
`define POD_CHANNELS 8
`define POD_CHAN_BITS 3

// One compressed item is a format flag plus 16 data bits
`define POD_ITEM_BITS 17
// Three items per FIFO word
`define POD_WORD_BITS 51
// Five words per DRAM block
`define POD_BLOCK_WORDS 5

// Per-channel word FIFO
`define POD_FIFO_DEPTH 16
`define POD_FIFO_LEVEL_BITS 5
// Levels above this win the first arbitration pass
`define POD_FIFO_THRESHOLD 8

// DRAM side
`define POD_PTR_BITS 22
`define POD_ADDR_BITS 29
`define POD_DATA_BITS 256

`endif

//--- verilog/pod_pkg.sv
//////////////////////////////
// Shared types: compressed item, FIFO word union,
// assembled block and DRAM write request
//////////////////////////////

`include "pod_settings.svh"

package pod_pkg;

	// One compressed item
	typedef struct packed {
		// Format flag from the compressor
		logic fmt;
		logic [`POD_ITEM_BITS-2:0] data;
	} pod_item_t;

	// Item view of a word, item 0 in the top bits
	typedef struct packed {
		pod_item_t item0;
		pod_item_t item1;
		pod_item_t item2;
	} pod_word_items_t;

	// A FIFO word, moved raw or decoded by item
	typedef union packed {
		logic [`POD_WORD_BITS-1:0] raw;
		pod_word_items_t items;
	} pod_word_u;

	// Five words, word i at bits i*51 upward
	typedef logic [`POD_BLOCK_WORDS*`POD_WORD_BITS-1:0] pod_block_t;

	// One 256-bit DRAM write
	typedef struct packed {
		logic [`POD_ADDR_BITS-1:0] addr;
		logic [`POD_DATA_BITS-1:0] data;
	} pod_wr_req_t;

endpackage

//--- verilog/pod_word_fifo.sv
//////////////////////////////
// Single-clock word FIFO with fill level
//////////////////////////////

`include "pod_settings.svh"

module pod_word_fifo import pod_pkg::*; (
	input logic clk_ram,
	input logic rst,

	// Push side, never stalled
	input logic wr_en,
	input pod_word_u wr_word,

	// Pop side, data one cycle after rd_en
	input logic rd_en,
	output pod_word_u rd_word,
	output logic empty,
	output logic [`POD_FIFO_LEVEL_BITS-1:0] level
);

	localparam int ADDR_BITS = $clog2(`POD_FIFO_DEPTH);

	pod_word_u mem [`POD_FIFO_DEPTH];

	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic full;
	logic wr_accept;
	logic rd_accept;

	assign full = (level == `POD_FIFO_LEVEL_BITS'(`POD_FIFO_DEPTH));
	assign empty = (level == '0);

	// Overflowing words are lost
	assign wr_accept = wr_en && !full;
	assign rd_accept = rd_en && !empty;

	// Pointers and fill count
	always_ff @(posedge clk_ram) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (wr_accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_accept)
				rd_ptr <= rd_ptr + 1'b1;
			level <= level + `POD_FIFO_LEVEL_BITS'(wr_accept)
				- `POD_FIFO_LEVEL_BITS'(rd_accept);
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk_ram) begin
		if (wr_accept)
			mem[wr_ptr] <= wr_word;
		if (rd_accept)
			rd_word <= mem[rd_ptr];
	end

	//////////////////////////////
	// Checks

	// The assembler only pops a word that is there
	a_no_underflow: assert property (@(posedge clk_ram) disable iff (rst)
		!(rd_en && empty));

endmodule

//--- verilog/pod_block_assembler.sv
//////////////////////////////
// Groups five FIFO words into one DRAM block
//////////////////////////////

`include "pod_settings.svh"

module pod_block_assembler import pod_pkg::*; (
	input logic clk_ram,
	input logic rst,

	// FIFO read side
	input logic word_empty,
	output logic rd_en,
	input pod_word_u rd_word,

	// Block towards the writer
	input logic clear,
	output pod_block_t block,
	output logic block_valid
);

	// Words already stored
	logic [2:0] count;
	// A read issued last cycle, data arriving now
	logic rd_valid;
	// Words stored by the end of this cycle
	logic [2:0] count_fwd;

	//////////////////////////////
	// Pop control

	always_comb begin
		count_fwd = count + 3'(rd_valid);
		rd_en = 1'b0;
		if (!word_empty) begin
			// Keep filling a block that is not complete
			if (!block_valid && (count_fwd < 3'(`POD_BLOCK_WORDS)))
				rd_en = 1'b1;
			// Block consumed, start the next one right away
			if (clear)
				rd_en = 1'b1;
		end
	end

	//////////////////////////////
	// Fill state

	always_ff @(posedge clk_ram) begin
		if (rst) begin
			rd_valid <= 1'b0;
			count <= '0;
			block_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
			count <= count_fwd;
			if (count_fwd == 3'(`POD_BLOCK_WORDS))
				block_valid <= 1'b1;
			// Clear wins over a completing block
			if (clear) begin
				block_valid <= 1'b0;
				count <= '0;
			end
		end
	end

	// Returned word goes to the slot named by the stored count
	always_ff @(posedge clk_ram) begin
		if (rd_valid)
			block[count*`POD_WORD_BITS +: `POD_WORD_BITS] <= rd_word.raw;
	end

	//////////////////////////////
	// Checks

	// Reads in flight never overfill a block
	a_count_max: assert property (@(posedge clk_ram) disable iff (rst)
		count_fwd <= 3'(`POD_BLOCK_WORDS));

endmodule

//--- verilog/pod_write_arbiter.sv
//////////////////////////////
// Two-pass selection of the next channel to write
//////////////////////////////

`include "pod_settings.svh"

module pod_write_arbiter import pod_pkg::*; (
	input logic clk_ram,
	input logic rst,

	// Complete blocks not being cleared
	input logic [`POD_CHANNELS-1:0] block_ready,
	input logic [`POD_FIFO_LEVEL_BITS-1:0] levels [`POD_CHANNELS],

	output logic grant_valid,
	output logic [`POD_CHAN_BITS-1:0] grant_channel
);

	logic sel_valid;
	logic [`POD_CHAN_BITS-1:0] sel_channel;

	// Later hits override earlier ones, so the highest channel wins
	always_comb begin
		sel_valid = 1'b0;
		sel_channel = '0;
		// Pass one, channels past the threshold
		for (int i = 0; i < `POD_CHANNELS; i++) begin
			if (block_ready[i] && (levels[i] > `POD_FIFO_THRESHOLD)) begin
				sel_valid = 1'b1;
				sel_channel = `POD_CHAN_BITS'(i);
			end
		end
		// Pass two, any ready channel
		if (!sel_valid) begin
			for (int i = 0; i < `POD_CHANNELS; i++) begin
				if (block_ready[i]) begin
					sel_valid = 1'b1;
					sel_channel = `POD_CHAN_BITS'(i);
				end
			end
		end
	end

	always_ff @(posedge clk_ram) begin
		if (rst) begin
			grant_valid <= 1'b0;
			grant_channel <= '0;
		end else begin
			grant_valid <= sel_valid;
			grant_channel <= sel_channel;
		end
	end

endmodule

//--- verilog/pod_dram_writer.sv
//////////////////////////////
// DRAM write issue: per-channel pointers,
// address build, pending write and block clear
//////////////////////////////

`include "pod_settings.svh"

module pod_dram_writer import pod_pkg::*; #(
	parameter int pod_number = 0
) (
	input logic clk_ram,
	input logic rst,

	// From the arbiter
	input logic grant_valid,
	input logic [`POD_CHAN_BITS-1:0] grant_channel,

	// Assembled blocks and their clear strobes
	input pod_block_t blocks [`POD_CHANNELS],
	output logic [`POD_CHANNELS-1:0] clear,

	// DRAM write port
	output logic ram_wr_en,
	output pod_wr_req_t ram_wr_req,
	input logic ram_wr_done
);

	// Each channel owns 2^22 block slots
	logic [`POD_PTR_BITS-1:0] wr_ptr [`POD_CHANNELS];
	logic pending;
	logic issue;

	// One write outstanding at most
	assign issue = grant_valid && !pending;

	//////////////////////////////
	// Control

	always_ff @(posedge clk_ram) begin
		if (rst) begin
			ram_wr_en <= 1'b0;
			clear <= '0;
			pending <= 1'b0;
			for (int i = 0; i < `POD_CHANNELS; i++)
				wr_ptr[i] <= '0;
		end else begin
			// Strobes last one cycle
			ram_wr_en <= 1'b0;
			clear <= '0;
			if (ram_wr_done)
				pending <= 1'b0;
			if (issue) begin
				ram_wr_en <= 1'b1;
				pending <= 1'b1;
				clear[grant_channel] <= 1'b1;
				wr_ptr[grant_channel] <= wr_ptr[grant_channel] + 1'b1;
			end
		end
	end

	// Address is 1, pod bit, channel, pointer, two zero bits
	always_ff @(posedge clk_ram) begin
		if (issue) begin
			ram_wr_req.addr <= {1'b1, pod_number[0], grant_channel,
				wr_ptr[grant_channel], 2'b00};
			// Zero pad bit on top, word 0 lowest
			ram_wr_req.data <= {1'b0, blocks[grant_channel]};
		end
	end

	//////////////////////////////
	// Checks

	// No second write until the memory reports the first done
	a_one_outstanding: assert property (@(posedge clk_ram) disable iff (rst)
		ram_wr_en |=> (!ram_wr_en until ram_wr_done));

endmodule

//--- verilog/pod_capture_top.sv
//////////////////////////////
// Capture path top: eight channel slices,
// write arbiter and DRAM writer
//////////////////////////////

`include "pod_settings.svh"

module pod_capture_top import pod_pkg::*; #(
	parameter int pod_number = 0
) (
	input logic clk_ram,
	input logic rst,

	// Compressed words, one strobe per channel
	input logic [`POD_CHANNELS-1:0] push,
	input pod_word_u push_word [`POD_CHANNELS],

	// DRAM write port
	output logic ram_wr_en,
	output pod_wr_req_t ram_wr_req,
	input logic ram_wr_done
);

	logic [`POD_CHANNELS-1:0] fifo_rd_en;
	logic [`POD_CHANNELS-1:0] fifo_empty;
	pod_word_u fifo_rd_word [`POD_CHANNELS];
	logic [`POD_FIFO_LEVEL_BITS-1:0] fifo_level [`POD_CHANNELS];

	pod_block_t blocks [`POD_CHANNELS];
	logic [`POD_CHANNELS-1:0] block_valid;
	logic [`POD_CHANNELS-1:0] clear;

	logic grant_valid;
	logic [`POD_CHAN_BITS-1:0] grant_channel;

	//////////////////////////////
	// Channel slices

	for (genvar g = 0; g < `POD_CHANNELS; g++) begin : g_chan
		pod_word_fifo u_fifo (
			.clk_ram (clk_ram),
			.rst     (rst),
			.wr_en   (push[g]),
			.wr_word (push_word[g]),
			.rd_en   (fifo_rd_en[g]),
			.rd_word (fifo_rd_word[g]),
			.empty   (fifo_empty[g]),
			.level   (fifo_level[g])
		);

		pod_block_assembler u_asm (
			.clk_ram     (clk_ram),
			.rst         (rst),
			.word_empty  (fifo_empty[g]),
			.rd_en       (fifo_rd_en[g]),
			.rd_word     (fifo_rd_word[g]),
			.clear       (clear[g]),
			.block       (blocks[g]),
			.block_valid (block_valid[g])
		);
	end

	//////////////////////////////
	// Arbitration and DRAM writes

	// A block being cleared this cycle is no longer offered
	pod_write_arbiter u_arb (
		.clk_ram       (clk_ram),
		.rst           (rst),
		.block_ready   (block_valid & ~clear),
		.levels        (fifo_level),
		.grant_valid   (grant_valid),
		.grant_channel (grant_channel)
	);

	pod_dram_writer #(
		.pod_number (pod_number)
	) u_writer (
		.clk_ram       (clk_ram),
		.rst           (rst),
		.grant_valid   (grant_valid),
		.grant_channel (grant_channel),
		.blocks        (blocks),
		.clear         (clear),
		.ram_wr_en     (ram_wr_en),
		.ram_wr_req    (ram_wr_req),
		.ram_wr_done   (ram_wr_done)
	);

endmodule

//--- verif/pod_capture_checker.sv
//////////////////////////////
// Reference model of expected DRAM writes
// and comparison of every write the DUT issues
//////////////////////////////

`include "pod_settings.svh"

module pod_capture_checker import pod_pkg::*; #(
	parameter int pod_number = 0
) (
	input logic clk_ram,
	input logic rst,
	input logic [`POD_CHANNELS-1:0] push,
	input pod_word_u push_word [`POD_CHANNELS],
	input logic ram_wr_en,
	input pod_wr_req_t ram_wr_req,
	input logic ram_wr_done
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORD_LIMIT = 64;

	// Pushed words per channel, in push order
	pod_word_u words [`POD_CHANNELS][WORD_LIMIT];
	int wr_idx [`POD_CHANNELS];
	int rd_idx [`POD_CHANNELS];
	// Expected DRAM pointer per channel
	logic [`POD_PTR_BITS-1:0] ptr [`POD_CHANNELS];

	string test_name = "reset";
	int order_chan = -1;
	int write_count = 0;
	int mismatch_count = 0;
	int protocol_count = 0;
	logic outstanding = 1'b0;

	task automatic begin_test(input string name, input int chan);
		test_name = name;
		order_chan = chan;
	endtask

	task automatic check_write_count(input int expected);
		if (write_count != expected) begin
			mismatch_count++;
			$display("mismatch %s write count expected %0d actual %0d",
				test_name, expected, write_count);
		end
	endtask

	//////////////////////////////
	// One DRAM write against the model

	task automatic check_write();
		logic [`POD_CHAN_BITS-1:0] ch;
		logic [`POD_ADDR_BITS-1:0] exp_addr;
		pod_word_u exp_w;
		pod_word_u act_w;
		ch = ram_wr_req.addr[26:24];
		write_count++;
		if (outstanding) begin
			protocol_count++;
			$display("second DRAM write issued in test %s before the first was done", test_name);
		end
		outstanding = 1'b1;
		if (order_chan >= 0) begin
			if (int'(ch) != order_chan) begin
				mismatch_count++;
				$display("mismatch %s write channel expected %0d actual %0d",
					test_name, order_chan, ch);
			end
			order_chan = -1;
		end
		if (wr_idx[ch] - rd_idx[ch] < `POD_BLOCK_WORDS) begin
			protocol_count++;
			$display("DRAM write on channel %0d in test %s without five words pushed",
				ch, test_name);
			return;
		end
		// 1, pod bit, channel, pointer, 2 zero bits
		exp_addr = {1'b1, 1'(pod_number % 2), ch, ptr[ch], 2'b00};
		if (ram_wr_req.addr !== exp_addr) begin
			mismatch_count++;
			$display("mismatch %s address expected %h actual %h",
				test_name, exp_addr, ram_wr_req.addr);
		end
		// Word 0 in the lowest bits, compared item by item
		for (int i = 0; i < `POD_BLOCK_WORDS; i++) begin
			exp_w = words[ch][rd_idx[ch] + i];
			act_w.raw = ram_wr_req.data[i*`POD_WORD_BITS +: `POD_WORD_BITS];
			if (act_w !== exp_w) begin
				mismatch_count++;
				$display("mismatch %s ch %0d word %0d expected %h %h %h actual %h %h %h",
					test_name, ch, i, exp_w.items.item0, exp_w.items.item1,
					exp_w.items.item2, act_w.items.item0, act_w.items.item1,
					act_w.items.item2);
			end
		end
		if (ram_wr_req.data[`POD_DATA_BITS-1] !== 1'b0) begin
			mismatch_count++;
			$display("mismatch %s pad bit expected 0 actual %b",
				test_name, ram_wr_req.data[`POD_DATA_BITS-1]);
		end
		rd_idx[ch] += `POD_BLOCK_WORDS;
		ptr[ch] = ptr[ch] + 1'b1;
	endtask

	//////////////////////////////
	// Monitor, sampled mid-cycle

	always @(negedge clk_ram) begin
		if (rst) begin
			outstanding = 1'b0;
			for (int ch = 0; ch < `POD_CHANNELS; ch++) begin
				wr_idx[ch] = 0;
				rd_idx[ch] = 0;
				ptr[ch] = '0;
			end
		end else begin
			if (ram_wr_done) begin
				if (!outstanding) begin
					protocol_count++;
					$display("ram_wr_done seen in test %s with no write outstanding", test_name);
				end
				outstanding = 1'b0;
			end
			if (ram_wr_en)
				check_write();
			for (int ch = 0; ch < `POD_CHANNELS; ch++) begin
				if (push[ch] && wr_idx[ch] < WORD_LIMIT) begin
					words[ch][wr_idx[ch]] = push_word[ch];
					wr_idx[ch]++;
				end else if (push[ch]) begin
					protocol_count++;
					$display("too many words pushed on channel %0d for the model", ch);
				end
			end
		end
	end

endmodule

//--- verif/pod_capture_tb.sv
//////////////////////////////
// Capture path testbench with clock, reset and LFSR words
// Stimulus table, DRAM done responder and final report
//////////////////////////////

`include "pod_settings.svh"

module pod_capture_tb import pod_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int POD_NUMBER = 1;
	localparam int NUM_TESTS = 9;
	localparam int WAIT_LIMIT = 3000;
	localparam int QUIET_CYCLES = 20;
	localparam logic [31:0] LFSR_SEED = 32'h2a0eecce;

	// One row of the stimulus table
	typedef struct {
		string name;
		logic [`POD_CHANNELS-1:0] mask;
		int words;
		int done_delay;
		bit wait_writes;
		// Channel the next write must go to or -1 for any
		int order_chan;
	} test_entry_t;

	logic clk_ram;
	logic rst;
	logic [`POD_CHANNELS-1:0] push;
	pod_word_u push_word [`POD_CHANNELS];
	logic ram_wr_en;
	pod_wr_req_t ram_wr_req;
	logic ram_wr_done;

	test_entry_t tests [NUM_TESTS];
	int cur_test;
	int pushed_total [`POD_CHANNELS];
	int timeout_count;
	logic [31:0] lfsr_state;

	pod_capture_top #(
		.pod_number (POD_NUMBER)
	) u_pod_capture_top (
		.clk_ram     (clk_ram),
		.rst         (rst),
		.push        (push),
		.push_word   (push_word),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_req  (ram_wr_req),
		.ram_wr_done (ram_wr_done)
	);

	pod_capture_checker #(
		.pod_number (POD_NUMBER)
	) u_checker (
		.clk_ram     (clk_ram),
		.rst         (rst),
		.push        (push),
		.push_word   (push_word),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_req  (ram_wr_req),
		.ram_wr_done (ram_wr_done)
	);

	// 100 ns clock
	initial begin
		clk_ram = 1'b0;
		forever #50 clk_ram = ~clk_ram;
	end

	//////////////////////////////
	// Random words

	// Galois LFSR stepped once per bit taken
	function automatic logic next_bit();
		logic bit_out;
		bit_out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (bit_out)
			lfsr_state = lfsr_state ^ 32'hA3000000;
		return bit_out;
	endfunction

	function automatic pod_item_t make_item();
		pod_item_t item;
		item.fmt = next_bit();
		for (int b = 15; b >= 0; b--)
			item.data[b] = next_bit();
		return item;
	endfunction

	// Words are built item by item
	function automatic pod_word_u make_word();
		pod_word_u w;
		w.items.item0 = make_item();
		w.items.item1 = make_item();
		w.items.item2 = make_item();
		return w;
	endfunction

	//////////////////////////////
	// Stimulus helpers

	// All masked channels push together with one word per cycle
	task automatic push_words(input logic [`POD_CHANNELS-1:0] mask, input int words);
		for (int k = 0; k < words; k++) begin
			@(posedge clk_ram);
			#10;
			for (int ch = 0; ch < `POD_CHANNELS; ch++) begin
				push[ch] = mask[ch];
				if (mask[ch])
					push_word[ch] = make_word();
			end
		end
		@(posedge clk_ram);
		#10;
		push = '0;
	endtask

	task automatic wait_for_writes(input string name, input int expected);
		int cycles;
		cycles = 0;
		while (u_checker.write_count < expected && cycles < WAIT_LIMIT) begin
			@(posedge clk_ram);
			cycles++;
		end
		if (u_checker.write_count < expected) begin
			timeout_count++;
			$display("timeout in test %s: only %0d of %0d DRAM writes seen after %0d cycles",
				name, u_checker.write_count, expected, cycles);
		end
	endtask

	// Let the last write settle so that late extra writes show up
	task automatic hold_quiet();
		for (int i = 0; i < QUIET_CYCLES; i++)
			@(posedge clk_ram);
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (u_checker.outstanding && cycles < WAIT_LIMIT) begin
			@(posedge clk_ram);
			cycles++;
		end
		if (u_checker.outstanding) begin
			timeout_count++;
			$display("timeout at end of run: last DRAM write never completed");
		end
	endtask

	//////////////////////////////
	// Done responder

	// Pulse ram_wr_done the table's delay after each write
	initial begin
		int delay;
		forever begin
			@(negedge clk_ram);
			if (ram_wr_en) begin
				delay = tests[cur_test].done_delay;
				for (int i = 0; i < delay; i++)
					@(posedge clk_ram);
				#10;
				ram_wr_done = 1'b1;
				@(posedge clk_ram);
				#10;
				ram_wr_done = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Main sequence

	initial begin
		int expected;
		tests[0] = '{"idle", 8'h00, 0, 1, 1'b1, -1};
		tests[1] = '{"one_block_ch3", 8'h08, 5, 3, 1'b1, -1};
		tests[2] = '{"four_words_ch6", 8'h40, 4, 3, 1'b1, -1};
		tests[3] = '{"fifth_word_ch6", 8'h40, 1, 3, 1'b1, -1};
		tests[4] = '{"all_channels", 8'hff, 10, 2, 1'b1, -1};
		tests[5] = '{"slow_done", 8'h03, 5, 30, 1'b1, -1};
		// Channel 7 write held pending while channels 2 and 5 fill up
		tests[6] = '{"prio_hold", 8'h80, 5, 80, 1'b1, -1};
		tests[7] = '{"prio_fill_ch2", 8'h04, 10, 2, 1'b0, -1};
		// Channel 2 is past the threshold when the held write completes
		tests[8] = '{"prio_race", 8'h24, 5, 2, 1'b1, 2};

		rst = 1'b1;
		push = '0;
		ram_wr_done = 1'b0;
		for (int ch = 0; ch < `POD_CHANNELS; ch++) begin
			push_word[ch] = '0;
			pushed_total[ch] = 0;
		end
		lfsr_state = LFSR_SEED;
		cur_test = 0;
		timeout_count = 0;

		for (int i = 0; i < 10; i++)
			@(posedge clk_ram);
		#10;
		rst = 1'b0;

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_test = t;
			u_checker.begin_test(tests[t].name, tests[t].order_chan);
			push_words(tests[t].mask, tests[t].words);
			for (int ch = 0; ch < `POD_CHANNELS; ch++)
				if (tests[t].mask[ch])
					pushed_total[ch] += tests[t].words;
			if (tests[t].wait_writes) begin
				// One write per complete group of five words
				expected = 0;
				for (int ch = 0; ch < `POD_CHANNELS; ch++)
					expected += pushed_total[ch] / `POD_BLOCK_WORDS;
				wait_for_writes(tests[t].name, expected);
				hold_quiet();
				u_checker.check_write_count(expected);
			end
		end
		wait_idle();

		$display("errors: %0d mismatch, %0d protocol, %0d timeout",
			u_checker.mismatch_count, u_checker.protocol_count, timeout_count);
		if (u_checker.mismatch_count + u_checker.protocol_count + timeout_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verilog
verilog/pod_pkg.sv
verilog/pod_word_fifo.sv
verilog/pod_block_assembler.sv
verilog/pod_write_arbiter.sv
verilog/pod_dram_writer.sv
verilog/pod_capture_top.sv
verif/pod_capture_checker.sv
verif/pod_capture_tb.sv

//--- Bender.yml
package:
  name: pod_capture

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pod_pkg.sv
      - verilog/pod_word_fifo.sv
      - verilog/pod_block_assembler.sv
      - verilog/pod_write_arbiter.sv
      - verilog/pod_dram_writer.sv
      - verilog/pod_capture_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/pod_capture_checker.sv
      - verif/pod_capture_tb.sv
